// File: tile_stream_pkg.sv
// shared localparams of the tile stream input stage.
// feature map, tile, RAM and FIFO sizes.

package tile_stream_pkg;

    // ########################################
    // data and feature map
    // ########################################

    // width of one feature map word.
    localparam int DW = 16;

    // the feature map is in_fm[N_MAP][R_MAP][C_MAP], stored row-major.
    localparam int N_MAP = 4;
    localparam int R_MAP = 8;
    localparam int C_MAP = 8;

    // one RAM word per map position.
    localparam int RAM_DEPTH = N_MAP * R_MAP * C_MAP;
    localparam int AW = 8;

    // read data shows up this many edges after the address.
    localparam int RAM_LAT = 2;

    // ########################################
    // tile geometry
    // ########################################

    // tile sizes in channels, rows and columns.
    localparam int TN = 2;
    localparam int TR = 4;
    localparam int TC = 4;
    localparam int TILE_WORDS = TN * TR * TC;

    // width of the base coordinates and of the tile counters.
    localparam int BW = 4;

    // ########################################
    // output FIFO
    // ########################################

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW = 4;

    // almost-full leaves room for the words still in the RAM pipeline.
    localparam int AFULL_LEVEL = FIFO_DEPTH - RAM_LAT - 1;

endpackage

// File: tile_req_if.sv
// tile request interface between the top level and the tile reader.

`timescale 1ns/100ps

interface tile_req_if
    import tile_stream_pkg::*;
();
    // a one-cycle pulse that asks for a new tile.
    logic          start;
    // tile origin in channels, rows and columns.
    logic [BW-1:0] base_n;
    logic [BW-1:0] base_row;
    logic [BW-1:0] base_col;
    // high while a tile is in progress.
    logic          busy;
    // one-cycle pulse with the push of the last tile word.
    logic          done;

    // the requester drives the request and watches the status.
    modport master (output start, base_n, base_row, base_col, input busy, done);

    // the reader takes the request and reports its status.
    modport slave (input start, base_n, base_row, base_col, output busy, done);

endinterface

// File: nest3_counter.sv
// three nested wrap-around counters for the tile walk.

`timescale 1ns/100ps

module nest3_counter
    import tile_stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          ena,
    output logic [BW-1:0] cnt0,
    output logic [BW-1:0] cnt1,
    output logic [BW-1:0] cnt2,
    output logic          last
);
    logic max0;
    logic max1;
    logic max2;

    // each counter flags its own terminal value.
    assign max0 = (cnt0 == BW'(TC - 1));
    assign max1 = (cnt1 == BW'(TR - 1));
    assign max2 = (cnt2 == BW'(TN - 1));

    // the final position of the tile is reached when all three sit at their maximum.
    assign last = max0 & max1 & max2;

    // cnt0 is the column counter and steps on every enable.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt0 <= '0;
        end else if (ena) begin
            if (max0) begin
                cnt0 <= '0;
            end else begin
                cnt0 <= cnt0 + 1'b1;
            end
        end
    end

    // cnt1 is the row counter and steps when the column counter wraps.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt1 <= '0;
        end else if (ena && max0) begin
            if (max1) begin
                cnt1 <= '0;
            end else begin
                cnt1 <= cnt1 + 1'b1;
            end
        end
    end

    // cnt2 is the channel counter and steps when the row counter wraps.
    // after the last step all three are back at zero for the next tile.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt2 <= '0;
        end else if (ena && max0 && max1) begin
            if (max2) begin
                cnt2 <= '0;
            end else begin
                cnt2 <= cnt2 + 1'b1;
            end
        end
    end

endmodule

// File: fm_ram.sv
// feature map RAM with one write port and a two-cycle read port.

`timescale 1ns/100ps

module fm_ram
    import tile_stream_pkg::*;
(
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  logic [DW-1:0] wdata,
    input  logic [AW-1:0] raddr,
    output logic [DW-1:0] rdata
);
    // the storage array, one word per feature map position.
    logic [DW-1:0] mem [RAM_DEPTH];

    // the read address register of the synchronous macro.
    logic [AW-1:0] raddr_q;

    // the output register that adds the second cycle of latency.
    logic [DW-1:0] rdata_q;

    // ########################################
    // write port
    // ########################################

    // the testbench loads the map through this port before any tile runs.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ########################################
    // read port
    // ########################################

    // first edge captures the address, second edge captures the word.
    // so the data for an address seen in cycle t is on rdata in cycle t+2.
    always_ff @(posedge clk) begin
        raddr_q <= raddr;
        rdata_q <= mem[raddr_q];
    end

    assign rdata = rdata_q;

endmodule

// File: tile_reader.sv
// tile reader that walks a tile of the feature map.
// address generation, bounds check, latency alignment and FIFO push.

`timescale 1ns/100ps

module tile_reader
    import tile_stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    tile_req_if.slave     req,
    output logic [AW-1:0] ram_raddr,
    input  logic [DW-1:0] ram_rdata,
    input  logic          almost_full,
    output logic          fifo_push,
    output logic [DW-1:0] fifo_wdata
);
    // busy covers the whole tile, issue_on only the address phase.
    logic               busy_q;
    logic               issue_on;
    logic               start_ok;
    logic               issue;
    logic               done_w;

    // tile origin, held for the whole tile.
    logic [BW-1:0]      base_n_q;
    logic [BW-1:0]      base_row_q;
    logic [BW-1:0]      base_col_q;

    // position inside the tile from the nested counter.
    logic [BW-1:0]      cnt_col;
    logic [BW-1:0]      cnt_row;
    logic [BW-1:0]      cnt_ch;
    logic               cnt_last;

    // absolute map position, one bit wider so that a sum past the edge does not wrap.
    logic [BW:0]        pos_n;
    logic [BW:0]        pos_row;
    logic [BW:0]        pos_col;
    logic               in_bounds;
    logic [AW-1:0]      map_addr;

    // flags that travel alongside the RAM read latency.
    logic [RAM_LAT-1:0] vld_sr;
    logic [RAM_LAT-1:0] inb_sr;
    logic [RAM_LAT-1:0] last_sr;

    // ########################################
    // request control
    // ########################################

    // a start is only taken while idle.
    assign start_ok = req.start & ~busy_q;

    // one address per cycle unless the FIFO is close to full.
    assign issue = issue_on & ~almost_full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q   <= 1'b0;
            issue_on <= 1'b0;
        end else if (start_ok) begin
            busy_q   <= 1'b1;
            issue_on <= 1'b1;
        end else begin
            // the address phase ends with the last position of the tile.
            if (issue && cnt_last) begin
                issue_on <= 1'b0;
            end
            // busy drops once the last word has been pushed.
            if (done_w) begin
                busy_q <= 1'b0;
            end
        end
    end

    // the bases are captured with the accepted start.
    always_ff @(posedge clk) begin
        if (start_ok) begin
            base_n_q   <= req.base_n;
            base_row_q <= req.base_row;
            base_col_q <= req.base_col;
        end
    end

    // ########################################
    // address generation
    // ########################################

    nest3_counter i_nest3_counter (
        .clk  (clk),
        .rst  (rst),
        .ena  (issue),
        .cnt0 (cnt_col),
        .cnt1 (cnt_row),
        .cnt2 (cnt_ch),
        .last (cnt_last)
    );

    assign pos_n   = {1'b0, base_n_q} + {1'b0, cnt_ch};
    assign pos_row = {1'b0, base_row_q} + {1'b0, cnt_row};
    assign pos_col = {1'b0, base_col_q} + {1'b0, cnt_col};

    // positions past any edge of the map are padding.
    assign in_bounds = (pos_n < (BW+1)'(N_MAP)) &&
                       (pos_row < (BW+1)'(R_MAP)) &&
                       (pos_col < (BW+1)'(C_MAP));

    // row-major address, channel * R * C + row * C + column.
    assign map_addr = AW'(pos_n) * AW'(R_MAP * C_MAP) +
                      AW'(pos_row) * AW'(C_MAP) +
                      AW'(pos_col);

    // padding reads a harmless address and is replaced by zero later.
    assign ram_raddr = in_bounds ? map_addr : '0;

    // ########################################
    // latency alignment and push
    // ########################################

    // each stage moves one step per cycle, stalls only hold back new issues.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_sr  <= '0;
            inb_sr  <= '0;
            last_sr <= '0;
        end else begin
            vld_sr  <= {vld_sr[RAM_LAT-2:0], issue};
            inb_sr  <= {inb_sr[RAM_LAT-2:0], in_bounds};
            last_sr <= {last_sr[RAM_LAT-2:0], cnt_last};
        end
    end

    // the word of an address issued two cycles ago is on ram_rdata now.
    assign fifo_push  = vld_sr[RAM_LAT-1];
    assign fifo_wdata = inb_sr[RAM_LAT-1] ? ram_rdata : '0;

    // done comes with the push of the last word.
    assign done_w = vld_sr[RAM_LAT-1] & last_sr[RAM_LAT-1];

    assign req.busy = busy_q;
    assign req.done = done_w;

endmodule

// File: out_fm_fifo.sv
// synchronous first-word-fall-through FIFO for the tile words.
// almost-full for the reader, count-based empty for the consumer.

`timescale 1ns/100ps

module out_fm_fifo
    import tile_stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  logic [DW-1:0] wdata,
    output logic          almost_full,
    input  logic          pop,
    output logic [DW-1:0] rdata,
    output logic          empty
);
    // storage of the circular buffer.
    logic [DW-1:0]      mem [FIFO_DEPTH];

    // the depth is a power of two, so the pointers wrap by themselves.
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;

    // fill level from 0 to FIFO_DEPTH, hence one extra bit.
    logic [FIFO_AW:0]   count;

    logic               full;
    logic               push_ok;
    logic               pop_ok;

    // ########################################
    // status flags
    // ########################################

    assign full        = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign empty       = (count == '0);
    assign almost_full = (count >= (FIFO_AW+1)'(AFULL_LEVEL));

    // a push into a full FIFO and a pop from an empty one have no effect.
    assign push_ok = push & ~full;
    assign pop_ok  = pop & ~empty;

    // ########################################
    // storage and pointers
    // ########################################

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // the head word is visible whenever the FIFO is not empty.
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // a push and a pop in the same cycle leave the level alone.
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: tile_stream_top.sv
// top level of the tile stream input stage.
// feature map RAM, tile reader and output FIFO.

`timescale 1ns/100ps

module tile_stream_top
    import tile_stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    // tile request and status.
    input  logic          start,
    input  logic [BW-1:0] base_n,
    input  logic [BW-1:0] base_row,
    input  logic [BW-1:0] base_col,
    output logic          busy,
    output logic          done,
    // load port of the feature map.
    input  logic          ram_we,
    input  logic [AW-1:0] ram_waddr,
    input  logic [DW-1:0] ram_wdata,
    // consumer side of the FIFO.
    input  logic          pop,
    output logic [DW-1:0] pop_data,
    output logic          empty
);
    // read path between reader and RAM.
    logic [AW-1:0] ram_raddr;
    logic [DW-1:0] ram_rdata;

    // push path between reader and FIFO.
    logic          fifo_push;
    logic [DW-1:0] fifo_wdata;
    logic          almost_full;

    // the external request pins are carried to the reader on one interface.
    tile_req_if req_if ();

    assign req_if.start    = start;
    assign req_if.base_n   = base_n;
    assign req_if.base_row = base_row;
    assign req_if.base_col = base_col;
    assign busy            = req_if.busy;
    assign done            = req_if.done;

    fm_ram i_fm_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    tile_reader i_tile_reader (
        .clk         (clk),
        .rst         (rst),
        .req         (req_if.slave),
        .ram_raddr   (ram_raddr),
        .ram_rdata   (ram_rdata),
        .almost_full (almost_full),
        .fifo_push   (fifo_push),
        .fifo_wdata  (fifo_wdata)
    );

    out_fm_fifo i_out_fm_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (fifo_push),
        .wdata       (fifo_wdata),
        .almost_full (almost_full),
        .pop         (pop),
        .rdata       (pop_data),
        .empty       (empty)
    );

endmodule

// File: tile_stream_props.sv
// bound protocol assertions for the output FIFO and the tile reader.
// one module, bound once to each of the two blocks.

`timescale 1ns/100ps

module tile_stream_props (
    input logic clk,
    input logic rst,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty,
    input logic busy,
    input logic done
);
    // number of assertion failures, read by the testbench at the end of the run.
    int unsigned fail_cnt = 0;

    // the almost-full margin must keep the in-flight words from hitting a full FIFO.
    a_no_push_full : assert property (@(posedge clk) disable iff (rst) full |-> !push)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("push while the FIFO is full");
        end

    // done marks exactly one cycle, the push of the last tile word.
    a_done_pulse : assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("done stayed high for more than one cycle");
        end

    // the reader only goes idle right after it reported done.
    a_busy_after_done : assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> $past(done))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("busy fell without a done pulse");
        end

    // a pop on an empty FIFO must not underflow the fill count.
    a_no_pop_empty : assert property (@(posedge clk) disable iff (rst)
        (pop && empty && !push) |=> empty)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("a pop took effect while the FIFO was empty");
        end

endmodule

// the FIFO instance has no tile status, so those inputs are tied off.
bind out_fm_fifo tile_stream_props i_fifo_props (
    .clk   (clk),
    .rst   (rst),
    .push  (push),
    .full  (full),
    .pop   (pop),
    .empty (empty),
    .busy  (1'b0),
    .done  (1'b0)
);

// the reader sees no FIFO fill state, so the FIFO inputs are tied off.
bind tile_reader tile_stream_props i_reader_props (
    .clk   (clk),
    .rst   (rst),
    .push  (fifo_push),
    .full  (1'b0),
    .pop   (1'b0),
    .empty (1'b1),
    .busy  (busy_q),
    .done  (done_w)
);

// File: tile_stream_tb.sv
// testbench for the tile stream input stage.
// LFSR stimulus, tile reference model, pop driver, checks and watchdog.

`timescale 1ns/100ps

module tile_stream_tb
    import tile_stream_pkg::*;
();
    // four directed tiles and ten random ones.
    localparam int NUM_TILES  = 14;
    localparam int MAX_CYCLES = 40 * (TILE_WORDS + 8) * NUM_TILES;

    logic          clk;
    logic          rst;
    logic          start;
    logic [BW-1:0] base_n;
    logic [BW-1:0] base_row;
    logic [BW-1:0] base_col;
    logic          busy;
    logic          done;
    logic          ram_we;
    logic [AW-1:0] ram_waddr;
    logic [DW-1:0] ram_wdata;
    logic          pop;
    logic [DW-1:0] pop_data;
    logic          empty;

    // copy of everything written into the feature map RAM.
    logic [DW-1:0] ram_copy [RAM_DEPTH];
    // words still expected from the tile in progress.
    logic [DW-1:0] exp_q [$];
    logic [31:0]   lfsr;
    int            cycle_cnt = 0;
    int            err_cnt   = 0;
    int            tests_ok  = 0;
    int            tests_bad = 0;

    tile_stream_top i_tile_stream_top (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .base_n    (base_n),
        .base_row  (base_row),
        .base_col  (base_col),
        .busy      (busy),
        .done      (done),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // the watchdog ends a run that stopped making progress.
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ########################################
    // helpers
    // ########################################

    // fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken.
    task automatic draw_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("error, %s at %0t", msg, $time);
        err_cnt++;
    endtask

    // the tile walks columns fastest, then rows, then channels.
    // positions off the map read as zero padding.
    task automatic build_expected(input int bn, input int br, input int bc);
        int pn;
        int pr;
        int pc;
        exp_q.delete();
        for (int n = 0; n < TN; n++) begin
            for (int r = 0; r < TR; r++) begin
                for (int c = 0; c < TC; c++) begin
                    pn = bn + n;
                    pr = br + r;
                    pc = bc + c;
                    if (pn < N_MAP && pr < R_MAP && pc < C_MAP) begin
                        exp_q.push_back(ram_copy[(pn * R_MAP + pr) * C_MAP + pc]);
                    end else begin
                        exp_q.push_back('0);
                    end
                end
            end
        end
    endtask

    // ########################################
    // one tile from start to done
    // ########################################

    // pop_mode 0 pops every cycle, 1 about one cycle in four, 2 on a random bit.
    task automatic run_tile(input string name, input int bn, input int br, input int bc,
                            input int pop_mode, input bit second_start);
        int          words;
        int          dones;
        int          errs_before;
        int          step;
        logic [31:0] allow;
        errs_before = err_cnt;
        words       = 0;
        dones       = 0;
        step        = 0;
        build_expected(bn, br, bc);
        @(negedge clk);
        start    = 1'b1;
        base_n   = BW'(bn);
        base_row = BW'(br);
        base_col = BW'(bc);
        while (!(words == TILE_WORDS && dones > 0 && !busy)) begin
            @(negedge clk);
            step++;
            // a stray start with other bases lands in the middle of the transfer.
            start = second_start && (step == 4);
            if (start) begin
                base_n   = ~base_n;
                base_row = ~base_row;
                base_col = ~base_col;
            end
            if (done) begin
                dones++;
            end
            case (pop_mode)
                0: allow = 32'd1;
                1: begin
                    draw_bits(2, allow);
                    allow = (allow == 0);
                end
                default: draw_bits(1, allow);
            endcase
            pop = 1'b0;
            // the head word is valid at the falling edge while empty is low.
            if (!empty && allow[0]) begin
                if (exp_q.size() == 0) begin
                    note_error("a word was popped beyond the end of the tile");
                end else begin
                    check_val("pop_data", pop_data, exp_q.pop_front());
                end
                words++;
                pop = 1'b1;
            end
        end
        // a few idle cycles to catch late words or a second done.
        // the consumer keeps popping, and a pop on the empty FIFO must be ignored.
        repeat (4) begin
            @(negedge clk);
            if (done) begin
                dones++;
            end
            if (!empty) begin
                note_error("a word arrived after the end of the tile");
            end
            pop = 1'b1;
        end
        @(negedge clk);
        pop = 1'b0;
        check_val("done_count", dones, 1);
        check_val("word_count", words, TILE_WORDS);
        check_val("empty", empty, 1'b1);
        check_val("busy", busy, 1'b0);
        if (err_cnt == errs_before) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("%-14s bases %0d/%0d/%0d words %0d : %s", name, bn, br, bc, words,
                 (err_cnt == errs_before) ? "ok" : "bad");
    endtask

    // ########################################
    // main sequence
    // ########################################

    initial begin
        logic [31:0] r;
        int          bn;
        int          br;
        int          bc;
        lfsr      = 32'h1c10602d;
        rst       = 1'b1;
        start     = 1'b0;
        base_n    = '0;
        base_row  = '0;
        base_col  = '0;
        ram_we    = 1'b0;
        ram_waddr = '0;
        ram_wdata = '0;
        pop       = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_val("busy", busy, 1'b0);
        check_val("done", done, 1'b0);
        check_val("empty", empty, 1'b1);
        $display("reset state checked, errors %0d", err_cnt);

        // the whole map is filled with LFSR words before any tile runs.
        for (int a = 0; a < RAM_DEPTH; a++) begin
            draw_bits(DW, r);
            ram_copy[a] = r[DW-1:0];
            ram_we      = 1'b1;
            ram_waddr   = AW'(a);
            ram_wdata   = r[DW-1:0];
            @(negedge clk);
        end
        ram_we = 1'b0;
        @(negedge clk);

        run_tile("interior", 1, 2, 2, 0, 1'b0);
        run_tile("edge", 3, 6, 6, 0, 1'b0);
        run_tile("back_pressure", 0, 1, 3, 1, 1'b0);
        run_tile("start_busy", 2, 0, 1, 0, 1'b1);
        for (int t = 0; t < 10; t++) begin
            draw_bits(2, r);
            bn = r;
            draw_bits(3, r);
            br = r;
            draw_bits(3, r);
            bc = r;
            run_tile("random", bn, br, bc, 2, 1'b0);
        end

        // failures of the bound assertions count as errors too.
        err_cnt += i_tile_stream_top.i_out_fm_fifo.i_fifo_props.fail_cnt;
        err_cnt += i_tile_stream_top.i_tile_reader.i_reader_props.fail_cnt;
        $display("tiles ok %0d bad %0d, errors %0d", tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tile_stream.f
tile_stream_pkg.sv
tile_req_if.sv
nest3_counter.sv
fm_ram.sv
tile_reader.sv
out_fm_fifo.sv
tile_stream_top.sv
tile_stream_props.sv
tile_stream_tb.sv

// File: Bender.yml
package:
  name: tile_stream

sources:
  - files:
      - tile_stream_pkg.sv
      - tile_req_if.sv
      - nest3_counter.sv
      - fm_ram.sv
      - tile_reader.sv
      - out_fm_fifo.sv
      - tile_stream_top.sv
  - target: test
    files:
      - tile_stream_props.sv
      - tile_stream_tb.sv
